// File: rtl/rv32m_alu.sv
// Combinational integer unit for add, sub, logic, shifts and set-less-than
`default_nettype none
`timescale 1ns/1ps

module rv32m_alu (
  input  rv32m_exec_pkg::alu_op_e op,
  input  logic [31:0]             a,
  input  logic [31:0]             b,
  output logic [31:0]             value
);

  import rv32m_exec_pkg::*;

  logic [32:0] diff;   // One spare bit keeps the unsigned borrow
  logic [4:0]  shamt;
  logic        lt_s;
  logic        lt_u;

  assign diff  = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];

  // Compares reuse the subtractor
  assign lt_u = diff[32];
  assign lt_s = (a[31] ^ b[31]) ? a[31] : diff[31];

  always_comb
  begin
    case (op)
      alu_add:  value = a + b;
      alu_sub:  value = diff[31:0];
      alu_and:  value = a & b;
      alu_or:   value = a | b;
      alu_xor:  value = a ^ b;
      alu_sll:  value = a << shamt;
      alu_srl:  value = a >> shamt;
      alu_sra:  value = $signed(a) >>> shamt;  // Sign bit fills from the left
      alu_slt:  value = {31'b0, lt_s};
      alu_sltu: value = {31'b0, lt_u};
      default:  value = 32'b0;  // M group
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rv32m_decode.sv
// Decode stage, maps an OP or OP-IMM word and its operands onto an operation and registers it
`default_nettype none
`timescale 1ns/1ps

`include "rv32m_exec_macros.svh"

module rv32m_decode (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,
  input  rv32m_exec_pkg::instr_u instr,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  output rv32m_exec_pkg::dec_t   dec
);

  import rv32m_exec_pkg::*;

  alu_op_e     op_c;
  logic [31:0] b_c;
  logic [4:0]  rd_c;
  logic        illegal_c;

  logic        valid_q;
  logic        illegal_q;
  alu_op_e     op_q;
  logic [4:0]  rd_q;
  logic [31:0] a_q;
  logic [31:0] b_q;

  // Base integer op for a funct3, shared by OP and OP-IMM
  function automatic alu_op_e base_op(input logic [2:0] f3);
    alu_op_e r;
    r = alu_add;
    case (f3)
      `RV32M_F3_ADD:  r = alu_add;
      `RV32M_F3_SLL:  r = alu_sll;
      `RV32M_F3_SLT:  r = alu_slt;
      `RV32M_F3_SLTU: r = alu_sltu;
      `RV32M_F3_XOR:  r = alu_xor;
      `RV32M_F3_SR:   r = alu_srl;
      `RV32M_F3_OR:   r = alu_or;
      `RV32M_F3_AND:  r = alu_and;
    endcase
    return r;
  endfunction

  always_comb
  begin
    op_c      = alu_add;
    b_c       = rs2_data;
    rd_c      = instr.r.rd;
    illegal_c = 1'b0;
    case (instr.r.opcode)
      `RV32M_OPC_OP:
      begin
        case (instr.r.funct7)
          `RV32M_F7_BASE:   op_c = base_op(instr.r.funct3);
          `RV32M_F7_MULDIV: op_c = alu_op_e'(alu_mul + {2'b00, instr.r.funct3});
          `RV32M_F7_ALT:
          begin
            if (instr.r.funct3 == `RV32M_F3_ADD)
              op_c = alu_sub;
            else if (instr.r.funct3 == `RV32M_F3_SR)
              op_c = alu_sra;
            else
              illegal_c = 1'b1;
          end
          default: illegal_c = 1'b1;
        endcase
      end
      `RV32M_OPC_OPIMM:
      begin
        op_c = base_op(instr.i.funct3);
        b_c  = {{20{instr.i.imm[11]}}, instr.i.imm};
        if (instr.i.funct3 == `RV32M_F3_SLL || instr.i.funct3 == `RV32M_F3_SR)
        begin
          b_c = {27'b0, instr.i.imm[4:0]};  // Shift amount only
          if (instr.i.funct3 == `RV32M_F3_SR && instr.i.imm[11:5] == `RV32M_F7_ALT)
            op_c = alu_sra;
          else if (instr.i.imm[11:5] != `RV32M_F7_BASE)
            illegal_c = 1'b1;
        end
      end
      default: illegal_c = 1'b1;
    endcase
    if (illegal_c)
      rd_c = 5'd0;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
    else
    begin
      valid_q   <= instr_valid;
      illegal_q <= instr_valid & illegal_c;
    end
  end

  // Payload, only meaningful with valid_q
  always_ff @(posedge clk)
  begin
    op_q <= op_c;
    rd_q <= rd_c;
    a_q  <= rs1_data;
    b_q  <= b_c;
  end

  assign dec = '{valid: valid_q, illegal: illegal_q, op: op_q, rd: rd_q, a: a_q, b: b_q};

endmodule

`default_nettype wire

// File: rtl/rv32m_exec_macros.svh
// RV32 opcode, funct3 and funct7 encodings, included by the decoder and by the checker model
`ifndef RV32M_EXEC_MACROS_SVH
`define RV32M_EXEC_MACROS_SVH

// Major opcodes handled by the slice
`define RV32M_OPC_OP     7'b0110011
`define RV32M_OPC_OPIMM  7'b0010011

// funct7 field
`define RV32M_F7_BASE    7'b0000000  // Normal ALU ops
`define RV32M_F7_ALT     7'b0100000  // SUB and SRA/SRAI
`define RV32M_F7_MULDIV  7'b0000001  // M extension

// funct3 field, base integer names
// M ops reuse the same codes in the order mul..remu
`define RV32M_F3_ADD     3'b000
`define RV32M_F3_SLL     3'b001
`define RV32M_F3_SLT     3'b010
`define RV32M_F3_SLTU    3'b011
`define RV32M_F3_XOR     3'b100
`define RV32M_F3_SR      3'b101  // SRL or SRA, picked by funct7
`define RV32M_F3_OR      3'b110
`define RV32M_F3_AND     3'b111

`endif

// File: rtl/rv32m_exec_pkg.sv
// Shared types of the execute slice: operation codes, instruction views and stage payloads
`default_nettype none

package rv32m_exec_pkg;

  // One code per operation, M group kept contiguous and in funct3 order
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_mul,
    alu_mulh,
    alu_mulhsu,
    alu_mulhu,
    alu_div,
    alu_divu,
    alu_rem,
    alu_remu
  } alu_op_e;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same 32-bit word, read as R or I depending on opcode
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  // Decode to execute
  typedef struct packed {
    logic        valid;
    logic        illegal;
    alu_op_e     op;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;  // rs2 value or extended immediate
  } dec_t;

  // Execute to result
  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] value;
  } exe_t;

endpackage

`default_nettype wire

// File: rtl/rv32m_exec_top.sv
// Top of the execute slice, chains decode, execute and result for a fixed three-cycle latency
`default_nettype none
`timescale 1ns/1ps

module rv32m_exec_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,
  input  rv32m_exec_pkg::instr_u instr,
  input  logic [31:0]            rs1_data,
  input  logic [31:0]            rs2_data,
  output logic                   result_valid,
  output logic                   illegal,
  output logic [4:0]             rd,
  output logic [31:0]            result,
  output logic                   zero,
  output logic                   wb_en
);

  import rv32m_exec_pkg::*;

  dec_t dec;  // Decode to execute
  exe_t exe;  // Execute to result

  rv32m_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .dec         (dec)
  );

  rv32m_execute u_execute (
    .clk    (clk),
    .arst_n (arst_n),
    .dec    (dec),
    .exe    (exe)
  );

  rv32m_result u_result (
    .clk          (clk),
    .arst_n       (arst_n),
    .exe          (exe),
    .result_valid (result_valid),
    .illegal      (illegal),
    .rd           (rd),
    .result       (result),
    .zero         (zero),
    .wb_en        (wb_en)
  );

endmodule

`default_nettype wire

// File: rtl/rv32m_execute.sv
// Execute stage, runs the decoded operands through the ALU and the M unit and registers the pick
`default_nettype none
`timescale 1ns/1ps

module rv32m_execute (
  input  logic                 clk,
  input  logic                 arst_n,
  input  rv32m_exec_pkg::dec_t dec,
  output rv32m_exec_pkg::exe_t exe
);

  import rv32m_exec_pkg::*;

  logic [31:0] alu_value;
  logic [31:0] md_value;
  logic        is_m;

  logic        valid_q;
  logic        illegal_q;
  logic [4:0]  rd_q;
  logic [31:0] value_q;

  rv32m_alu u_alu (
    .op    (dec.op),
    .a     (dec.a),
    .b     (dec.b),
    .value (alu_value)
  );

  rv32m_muldiv u_muldiv (
    .op    (dec.op),
    .a     (dec.a),
    .b     (dec.b),
    .value (md_value)
  );

  assign is_m = dec.op inside {[alu_mul:alu_remu]};

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
    else
    begin
      valid_q   <= dec.valid;
      illegal_q <= dec.illegal;
    end
  end

  always_ff @(posedge clk)
  begin
    rd_q    <= dec.rd;
    value_q <= is_m ? md_value : alu_value;
  end

  assign exe = '{valid: valid_q, illegal: illegal_q, rd: rd_q, value: value_q};

endmodule

`default_nettype wire

// File: rtl/rv32m_muldiv.sv
// Combinational M-extension unit, multiply high and low, divide and remainder with RISC-V corner rules
`default_nettype none
`timescale 1ns/1ps

module rv32m_muldiv (
  input  rv32m_exec_pkg::alu_op_e op,
  input  logic [31:0]             a,
  input  logic [31:0]             b,
  output logic [31:0]             value
);

  import rv32m_exec_pkg::*;

  logic               a_signed;
  logic               b_signed;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [65:0] prod;

  logic               div_signed;
  logic               div_zero;
  logic               div_ovf;
  logic [31:0]        divisor;
  logic [31:0]        q_s;
  logic [31:0]        r_s;
  logic [31:0]        q_u;
  logic [31:0]        r_u;

  // One 33x33 signed multiplier covers all three signedness mixes
  assign a_signed = (op == alu_mul) || (op == alu_mulh) || (op == alu_mulhsu);
  assign b_signed = (op == alu_mul) || (op == alu_mulh);
  assign a_ext    = {a_signed & a[31], a};
  assign b_ext    = {b_signed & b[31], b};
  assign prod     = a_ext * b_ext;

  assign div_signed = (op == alu_div) || (op == alu_rem);
  assign div_zero   = (b == 32'd0);
  assign div_ovf    = div_signed && (a == 32'h8000_0000) && (b == 32'hffff_ffff);

  // Divide by one in the overflow case already gives q = min, r = 0
  assign divisor = (div_zero || div_ovf) ? 32'd1 : b;

  assign q_s = $signed(a) / $signed(divisor);
  assign r_s = $signed(a) % $signed(divisor);
  assign q_u = a / divisor;
  assign r_u = a % divisor;

  always_comb
  begin
    case (op)
      alu_mul:    value = prod[31:0];
      alu_mulh,
      alu_mulhsu,
      alu_mulhu:  value = prod[63:32];  // Upper product word
      alu_div:    value = div_zero ? 32'hffff_ffff : q_s;
      alu_divu:   value = div_zero ? 32'hffff_ffff : q_u;
      alu_rem:    value = div_zero ? a : r_s;  // Dividend comes back on x/0
      alu_remu:   value = div_zero ? a : r_u;
      default:    value = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rv32m_result.sv
// Result stage, registers the outputs with the zero flag and the write-back enable
`default_nettype none
`timescale 1ns/1ps

module rv32m_result (
  input  logic                 clk,
  input  logic                 arst_n,
  input  rv32m_exec_pkg::exe_t exe,
  output logic                 result_valid,
  output logic                 illegal,
  output logic [4:0]           rd,
  output logic [31:0]          result,
  output logic                 zero,
  output logic                 wb_en
);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
      wb_en        <= 1'b0;
    end
    else
    begin
      result_valid <= exe.valid & ~exe.illegal;
      illegal      <= exe.valid & exe.illegal;  // Never together with result_valid
      wb_en        <= exe.valid & ~exe.illegal & (exe.rd != 5'd0);  // x0 is not written
    end
  end

  always_ff @(posedge clk)
  begin
    rd     <= exe.rd;
    result <= exe.value;
    zero   <= (exe.value == 32'd0);
  end

endmodule

`default_nettype wire

// File: rv32m_exec.f
+incdir+rtl
rtl/rv32m_exec_pkg.sv
rtl/rv32m_alu.sv
rtl/rv32m_muldiv.sv
rtl/rv32m_decode.sv
rtl/rv32m_execute.sv
rtl/rv32m_result.sv
rtl/rv32m_exec_top.sv
test/rv32m_exec_assertions.sv
test/rv32m_exec_tb.sv

// File: test/rv32m_exec_assertions.sv
// Checker bound to the slice top that replays each word three edges later in a reference model
`default_nettype none
`timescale 1ns/1ps

`include "rv32m_exec_macros.svh"

module rv32m_exec_assertions (
  input wire logic                   clk,
  input wire logic                   arst_n,
  input wire logic                   instr_valid,
  input wire rv32m_exec_pkg::instr_u instr,
  input wire logic [31:0]            rs1_data,
  input wire logic [31:0]            rs2_data,
  input wire logic                   result_valid,
  input wire logic                   illegal,
  input wire logic [4:0]             rd,
  input wire logic [31:0]            result,
  input wire logic                   zero,
  input wire logic                   wb_en
);

  int          fail_count = 0;  // Read by the testbench
  logic [2:0]  v_q;             // Bit 2 holds the valid of three edges back
  logic [31:0] w_q [3];
  logic [31:0] a_q [3];
  logic [31:0] b_q [3];
  logic        exp_ill;
  logic [31:0] exp_val;
  logic [4:0]  exp_rd;

  // Legal set of OP and OP-IMM encodings
  function automatic logic ref_illegal(input logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    logic       bad;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
      `RV32M_OPC_OP:
        bad = !(f7 == `RV32M_F7_BASE || f7 == `RV32M_F7_MULDIV ||
                (f7 == `RV32M_F7_ALT && (f3 == `RV32M_F3_ADD || f3 == `RV32M_F3_SR)));
      `RV32M_OPC_OPIMM:
      begin
        if (f3 == `RV32M_F3_SLL)
          bad = (f7 != `RV32M_F7_BASE);
        else if (f3 == `RV32M_F3_SR)
          bad = !(f7 == `RV32M_F7_BASE || f7 == `RV32M_F7_ALT);
        else
          bad = 1'b0;
      end
      default: bad = 1'b1;
    endcase
    return bad;
  endfunction

  // Expected value of a legal word for operands x and y
  function automatic logic [31:0] ref_value(input logic [31:0] w, input logic [31:0] x,
                                            input logic [31:0] y);
    logic [31:0] opb;
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic [63:0] p_uu;
    logic        imm;
    logic        alt;
    logic        ovf;
    logic [31:0] r;
    imm  = (w[6:0] == `RV32M_OPC_OPIMM);
    opb  = imm ? {{20{w[31]}}, w[31:20]} : y;
    alt  = (w[31:25] == `RV32M_F7_ALT);
    ovf  = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
    p_ss = {{32{x[31]}}, x} * {{32{y[31]}}, y};  // Low 64 bits of the signed product
    p_su = {{32{x[31]}}, x} * {32'd0, y};
    p_uu = {32'd0, x} * {32'd0, y};
    r    = 32'd0;
    if (!imm && w[31:25] == `RV32M_F7_MULDIV)
    begin
      case (w[14:12])
        3'd0: r = p_uu[31:0];
        3'd1: r = p_ss[63:32];
        3'd2: r = p_su[63:32];
        3'd3: r = p_uu[63:32];
        3'd4:
        begin
          if (y == 32'd0)
            r = 32'hffff_ffff;
          else if (ovf)
            r = 32'h8000_0000;
          else
            r = $signed(x) / $signed(y);
        end
        3'd5: r = (y == 32'd0) ? 32'hffff_ffff : x / y;
        3'd6:
        begin
          if (y == 32'd0)
            r = x;
          else if (ovf)
            r = 32'd0;
          else
            r = $signed(x) % $signed(y);
        end
        default: r = (y == 32'd0) ? x : x % y;
      endcase
    end
    else
    begin
      case (w[14:12])
        `RV32M_F3_ADD:  r = (!imm && alt) ? x - opb : x + opb;
        `RV32M_F3_SLL:  r = x << opb[4:0];
        `RV32M_F3_SLT:  r = {31'd0, $signed(x) < $signed(opb)};
        `RV32M_F3_SLTU: r = {31'd0, x < opb};
        `RV32M_F3_XOR:  r = x ^ opb;
        `RV32M_F3_OR:   r = x | opb;
        `RV32M_F3_AND:  r = x & opb;
        default:
        begin
          if (alt)
            r = $signed(x) >>> opb[4:0];
          else
            r = x >> opb[4:0];
        end
      endcase
    end
    return r;
  endfunction

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      v_q <= 3'b000;
    else
      v_q <= {v_q[1:0], instr_valid};
  end

  always_ff @(posedge clk)
  begin
    w_q[0] <= instr;
    a_q[0] <= rs1_data;
    b_q[0] <= rs2_data;
    for (int k = 1; k < 3; k++)
    begin
      w_q[k] <= w_q[k-1];
      a_q[k] <= a_q[k-1];
      b_q[k] <= b_q[k-1];
    end
  end

  assign exp_ill = ref_illegal(w_q[2]);
  assign exp_val = ref_value(w_q[2], a_q[2], b_q[2]);
  assign exp_rd  = w_q[2][11:7];

  a_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !v_q[2] |-> !result_valid && !illegal && !wb_en)
  else
  begin
    fail_count++;
    $error("CHECK FAILED idle_outputs expected 000 actual %b%b%b",
           $sampled(result_valid), $sampled(illegal), $sampled(wb_en));
  end

  a_valid: assert property (@(posedge clk) disable iff (!arst_n)
    v_q[2] && !exp_ill |-> result_valid && !illegal)
  else
  begin
    fail_count++;
    $error("CHECK FAILED result_valid expected 10 actual %b%b",
           $sampled(result_valid), $sampled(illegal));
  end

  a_rd: assert property (@(posedge clk) disable iff (!arst_n)
    v_q[2] && !exp_ill |-> rd == exp_rd)
  else
  begin
    fail_count++;
    $error("CHECK FAILED result_rd expected %0d actual %0d", $sampled(exp_rd), $sampled(rd));
  end

  a_value: assert property (@(posedge clk) disable iff (!arst_n)
    v_q[2] && !exp_ill |-> result == exp_val)
  else
  begin
    fail_count++;
    $error("CHECK FAILED result_value expected %h actual %h word %h",
           $sampled(exp_val), $sampled(result), $sampled(w_q[2]));
  end

  a_zero: assert property (@(posedge clk) disable iff (!arst_n)
    v_q[2] && !exp_ill |-> zero == (exp_val == 32'd0))
  else
  begin
    fail_count++;
    $error("CHECK FAILED zero_flag expected %b actual %b",
           $sampled(exp_val) == 32'd0, $sampled(zero));
  end

  a_wb: assert property (@(posedge clk) disable iff (!arst_n)
    wb_en == (v_q[2] && !exp_ill && exp_rd != 5'd0))
  else
  begin
    fail_count++;
    $error("CHECK FAILED wb_enable expected %b actual %b",
           $sampled(v_q[2]) && !$sampled(exp_ill) && $sampled(exp_rd) != 5'd0,
           $sampled(wb_en));
  end

  a_illegal: assert property (@(posedge clk) disable iff (!arst_n)
    v_q[2] && exp_ill |-> illegal && !result_valid && !wb_en)
  else
  begin
    fail_count++;
    $error("CHECK FAILED illegal_word expected 100 actual %b%b%b",
           $sampled(illegal), $sampled(result_valid), $sampled(wb_en));
  end

endmodule

bind rv32m_exec_top rv32m_exec_assertions u_check (
  .clk          (clk),
  .arst_n       (arst_n),
  .instr_valid  (instr_valid),
  .instr        (instr),
  .rs1_data     (rs1_data),
  .rs2_data     (rs2_data),
  .result_valid (result_valid),
  .illegal      (illegal),
  .rd           (rd),
  .result       (result),
  .zero         (zero),
  .wb_en        (wb_en)
);

`default_nettype wire

// File: test/rv32m_exec_tb.sv
// Testbench top for the execute slice, drives random and corner-case words while the bound checker compares
`default_nettype none
`timescale 1ns/1ps

`include "rv32m_exec_macros.svh"

module rv32m_exec_tb;

  import rv32m_exec_pkg::*;

  localparam int max_cycles = 600;  // About 440 words plus reset, gaps and drain

  logic        clk = 1'b0;
  logic        arst_n;
  logic        instr_valid;
  instr_u      instr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        result_valid;
  logic        illegal;
  logic [4:0]  rd;
  logic [31:0] result;
  logic        zero;
  logic        wb_en;

  integer      seed;
  int          cycles = 0;
  int          kind;

  rv32m_exec_top dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result_valid (result_valid),
    .illegal      (illegal),
    .rd           (rd),
    .result       (result),
    .zero         (zero),
    .wb_en        (wb_en)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
      abort_run("timeout, the run did not finish in time");
  end

  // Checker failures are picked up between edges
  always @(negedge clk)
  begin
    if (dut.u_check.fail_count != 0)
      abort_run("an assertion in the bound checker failed");
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] dst);
    return {f7, 5'd2, 5'd1, f3, dst, `RV32M_OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] dst);
    return {imm, 5'd1, f3, dst, `RV32M_OPC_OPIMM};
  endfunction

  // Kinds 0..17 are OP words, 18..26 are OP-IMM words
  function automatic logic [31:0] legal_word(input int k, input logic [31:0] rnd);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [11:0] imm;
    if (k < 18)
    begin
      f3 = rnd[14:12];
      f7 = (k < 8) ? `RV32M_F7_BASE : `RV32M_F7_MULDIV;
      if (k >= 16)
      begin
        f7 = `RV32M_F7_ALT;
        f3 = (k == 16) ? `RV32M_F3_ADD : `RV32M_F3_SR;
      end
      return {f7, rnd[24:20], rnd[19:15], f3, rnd[11:7], `RV32M_OPC_OP};
    end
    imm = rnd[31:20];
    f3  = (k == 26) ? `RV32M_F3_SR : 3'(k - 18);
    if (k == 26)
      imm[11:5] = `RV32M_F7_ALT;  // SRAI
    else if (f3 == `RV32M_F3_SLL || f3 == `RV32M_F3_SR)
      imm[11:5] = `RV32M_F7_BASE;
    return {imm, rnd[19:15], f3, rnd[11:7], `RV32M_OPC_OPIMM};
  endfunction

  task automatic send(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    instr_valid = 1'b1;
    instr       = w;
    rs1_data    = a;
    rs2_data    = b;
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    instr_valid = 1'b0;
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Corner values now and then, so zero divisors and overflow also show up at random
  task automatic pick_operand(output logic [31:0] v);
    logic [31:0] corner [5];
    corner = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    v = $random(seed);
    if (v[2:0] == 3'd0)
      v = corner[$unsigned($random(seed)) % 5];
  endtask

  task automatic send_random();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    kind = $unsigned($random(seed)) % 27;
    w    = legal_word(kind, $random(seed));
    pick_operand(a);
    pick_operand(b);
    send(w, a, b);
  endtask

  initial
  begin
    seed        = 32'ha64d;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    rs1_data    = 32'd0;
    rs2_data    = 32'd0;
    repeat (10) @(posedge clk);
    #2 arst_n = 1'b1;
    idle(3);

    // Division by zero and signed overflow
    send(r_word(`RV32M_F7_MULDIV, 3'd4, 5'd5), 32'd1234, 32'd0);
    send(r_word(`RV32M_F7_MULDIV, 3'd5, 5'd6), 32'hdead_beef, 32'd0);
    send(r_word(`RV32M_F7_MULDIV, 3'd6, 5'd7), 32'hdead_beef, 32'd0);
    send(r_word(`RV32M_F7_MULDIV, 3'd7, 5'd8), 32'd77, 32'd0);
    send(r_word(`RV32M_F7_MULDIV, 3'd4, 5'd9), 32'h8000_0000, 32'hffff_ffff);
    send(r_word(`RV32M_F7_MULDIV, 3'd6, 5'd10), 32'h8000_0000, 32'hffff_ffff);
    send(r_word(`RV32M_F7_MULDIV, 3'd5, 5'd11), 32'h8000_0000, 32'hffff_ffff);
    idle(2);

    send(r_word(`RV32M_F7_BASE, `RV32M_F3_ADD, 5'd0), 32'd5, 32'd6);  // rd = x0
    send(r_word(`RV32M_F7_ALT, `RV32M_F3_ADD, 5'd12), 32'd9, 32'd9);

    // Largest shift amounts
    send(r_word(`RV32M_F7_BASE, `RV32M_F3_SLL, 5'd13), 32'h8000_0001, 32'd31);
    send(r_word(`RV32M_F7_BASE, `RV32M_F3_SR, 5'd14), 32'h8000_0001, 32'hffff_ffff);
    send(r_word(`RV32M_F7_ALT, `RV32M_F3_SR, 5'd15), 32'h8000_0001, 32'd31);
    send(i_word(12'h01f, `RV32M_F3_SLL, 5'd16), 32'h8000_0001, 32'd0);
    send(i_word(12'h01f, `RV32M_F3_SR, 5'd17), 32'h8000_0001, 32'd0);
    send(i_word(12'h41f, `RV32M_F3_SR, 5'd18), 32'h8000_0001, 32'd0);
    send(r_word(`RV32M_F7_BASE, `RV32M_F3_SLT, 5'd19), 32'hffff_ffff, 32'd1);
    send(r_word(`RV32M_F7_BASE, `RV32M_F3_SLTU, 5'd20), 32'hffff_ffff, 32'd1);

    // Illegal words
    send(32'h0000_0a83, 32'd1, 32'd2);
    send(32'hffff_ffff, 32'd1, 32'd2);
    send(r_word(`RV32M_F7_ALT, `RV32M_F3_SLL, 5'd22), 32'd1, 32'd2);
    send(i_word(12'h405, `RV32M_F3_SLL, 5'd23), 32'd1, 32'd2);
    send(r_word(7'b1000000, `RV32M_F3_ADD, 5'd24), 32'd1, 32'd2);
    idle(1);

    repeat (418) send_random();
    idle(5);  // Three-cycle latency drains the last words

    if (dut.u_check.fail_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      abort_run("assertion failures were counted at the end of the run");
  end

endmodule

`default_nettype wire
